//--- rtl/enigma_cfg.svh
// Alphabet size, character width and letter position width
`ifndef ENIGMA_CFG_SVH
`define ENIGMA_CFG_SVH

// Letters on each rotor
`define ALPHABET_SIZE 26

// ASCII character width
`define CHAR_WIDTH 8

// Letter index and rotor position width
`define POS_WIDTH 5

`endif

//--- rtl/enigma_pkg.sv
// Letter, character and position types, FSM states, wiring tables and wiring inversion
`default_nettype none

`include "enigma_cfg.svh"

package enigma_pkg;

    typedef logic [`POS_WIDTH-1:0] letterIdx_t;
    typedef logic [`CHAR_WIDTH-1:0] asciiChar_t;

    typedef struct packed {
        letterIdx_t r1;
        letterIdx_t r2;
        letterIdx_t r3;
    } rotorPos_t;

    // Entry i gives the substituted index for letter i
    typedef letterIdx_t [0:`ALPHABET_SIZE-1] wiringTable_t;

    typedef enum logic {
        UNSET,
        READY
    } ctrlState_t;

    // Ten swapped pairs, O R S U X Y pass straight through
    localparam wiringTable_t PLUG_TABLE = '{
        4, 10, 12, 5, 0, 3, 11, 16, 21, 25, 1, 6, 2,
        22, 14, 19, 7, 17, 18, 15, 20, 8, 13, 23, 24, 9
    };

    localparam wiringTable_t [0:2] ROTOR_TABLES = '{
        '{7, 12, 21, 17, 0, 2, 22, 20, 23, 18, 9, 25, 15,
          3, 14, 13, 11, 8, 4, 10, 6, 5, 19, 16, 24, 1},
        '{19, 4, 7, 6, 12, 17, 8, 5, 2, 0, 1, 20, 25,
          9, 14, 22, 24, 18, 15, 13, 3, 10, 21, 16, 11, 23},
        '{19, 0, 6, 1, 15, 2, 18, 3, 16, 4, 20, 5, 21,
          13, 25, 7, 24, 8, 23, 9, 22, 11, 17, 10, 14, 12}
    };

    // Pairs only, no letter maps to itself
    localparam wiringTable_t REFLECT_TABLE = '{
        24, 17, 20, 7, 16, 18, 11, 3, 15, 23, 13, 6, 14,
        10, 12, 8, 4, 1, 5, 25, 2, 22, 21, 9, 0, 19
    };

    // Backward path through a rotor
    function automatic wiringTable_t invertWiring(input wiringTable_t fwd);
        wiringTable_t inv;
        inv = '0;
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            inv[fwd[i]] = letterIdx_t'(i);
        end
        return inv;
    endfunction

endpackage

`default_nettype wire

//--- rtl/enigmaControl.sv
// Control FSM for start position loading, letter acceptance and result pulses
`timescale 1ns/1ps
`default_nettype none

module enigmaControl
    import enigma_pkg::*;
(
    input  logic load,
    input  logic arstN,
    input  logic setStart,
    input  logic charValid,
    input  logic isLetter,
    output logic loadPos,
    output logic advance,
    output logic ready,
    output logic outValid,
    output logic charError
);

    ctrlState_t state;
    logic       badChar;

    assign ready   = (state == READY);
    assign loadPos = setStart;

    // setStart wins over a letter in the same cycle
    assign advance = charValid && ready && isLetter && !setStart;
    assign badChar = charValid && !setStart && (!ready || !isLetter);

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            state <= UNSET;
        end else if (setStart) begin
            state <= READY;
        end
    end

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            outValid  <= 1'b0;
            charError <= 1'b0;
        end else begin
            outValid  <= advance;
            charError <= badChar;
        end
    end

    // Start load is a single-cycle strobe
    assertStartStrobe: assert property (
        @(posedge load) disable iff (!arstN)
        setStart |=> !setStart
    );

endmodule

`default_nettype wire

//--- rtl/rotorStepper.sv
// Rotor position registers with start load and odometer stepping
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module rotorStepper
    import enigma_pkg::*;
(
    input  logic      load,
    input  logic      arstN,
    input  logic      loadPos,
    input  rotorPos_t startPos,
    input  logic      advance,
    output rotorPos_t pos
);

    localparam letterIdx_t LAST_POS = letterIdx_t'(`ALPHABET_SIZE - 1);

    logic r1Wrap;
    logic r2Wrap;

    function automatic letterIdx_t nextPos(input letterIdx_t p);
        return (p == LAST_POS) ? '0 : p + 1'b1;
    endfunction

    assign r1Wrap = (pos.r1 == LAST_POS);
    assign r2Wrap = (pos.r2 == LAST_POS);

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            pos <= '0;
        end else if (loadPos) begin
            pos <= startPos;
        end else if (advance) begin
            pos.r1 <= nextPos(pos.r1);
            // Carry ripples only on a wrap
            if (r1Wrap) begin
                pos.r2 <= nextPos(pos.r2);
                if (r2Wrap) begin
                    pos.r3 <= nextPos(pos.r3);
                end
            end
        end
    end

    assertPosInRange: assert property (
        @(posedge load) disable iff (!arstN)
        (pos.r1 < `ALPHABET_SIZE) && (pos.r2 < `ALPHABET_SIZE) &&
        (pos.r3 < `ALPHABET_SIZE)
    );

endmodule

`default_nettype wire

//--- rtl/rotorWheel.sv
// Single rotor substitution, forward and backward, corrected for rotor offset
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module rotorWheel
    import enigma_pkg::*;
#(
    parameter int ROTOR_ID = 1
) (
    input  letterIdx_t fwdIn,
    input  letterIdx_t bwdIn,
    input  letterIdx_t position,
    output letterIdx_t fwdOut,
    output letterIdx_t bwdOut
);

    localparam wiringTable_t FWD_TABLE = ROTOR_TABLES[ROTOR_ID-1];
    localparam wiringTable_t BWD_TABLE = invertWiring(FWD_TABLE);

    letterIdx_t fwdContact;
    letterIdx_t bwdContact;

    function automatic letterIdx_t addMod(input letterIdx_t a, input letterIdx_t b);
        logic [`POS_WIDTH:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= `ALPHABET_SIZE) begin
            sum = sum - `ALPHABET_SIZE;
        end
        return sum[`POS_WIDTH-1:0];
    endfunction

    function automatic letterIdx_t subMod(input letterIdx_t a, input letterIdx_t b);
        logic [`POS_WIDTH:0] diff;
        // Bias by one alphabet to stay positive
        diff = {1'b0, a} + `ALPHABET_SIZE - {1'b0, b};
        if (diff >= `ALPHABET_SIZE) begin
            diff = diff - `ALPHABET_SIZE;
        end
        return diff[`POS_WIDTH-1:0];
    endfunction

    // Contact under the entry point after rotation
    assign fwdContact = addMod(fwdIn, position);
    assign bwdContact = addMod(bwdIn, position);

    assign fwdOut = subMod(FWD_TABLE[fwdContact], position);
    assign bwdOut = subMod(BWD_TABLE[bwdContact], position);

endmodule

`default_nettype wire

//--- rtl/letterScrambler.sv
// Letter check and decode, plugboard, rotor stack, reflector and output register
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module letterScrambler
    import enigma_pkg::*;
(
    input  logic       load,
    input  logic       arstN,
    input  asciiChar_t charIn,
    input  rotorPos_t  pos,
    input  logic       advance,
    output logic       isLetter,
    output asciiChar_t outChar
);

    localparam asciiChar_t CHAR_A = "A";
    localparam asciiChar_t CHAR_Z = "Z";

    asciiChar_t charOffset;
    letterIdx_t inIdx;
    letterIdx_t plugFwd;
    letterIdx_t r1Fwd;
    letterIdx_t r2Fwd;
    letterIdx_t r3Fwd;
    letterIdx_t reflected;
    letterIdx_t r3Bwd;
    letterIdx_t r2Bwd;
    letterIdx_t r1Bwd;
    letterIdx_t plugBwd;
    asciiChar_t cipherChar;

    assign isLetter   = (charIn >= CHAR_A) && (charIn <= CHAR_Z);
    assign charOffset = charIn - CHAR_A;

    // Non-letters fold to index 0 so the tables stay in range
    assign inIdx = isLetter ? charOffset[`POS_WIDTH-1:0] : '0;

    assign plugFwd = PLUG_TABLE[inIdx];

    rotorWheel #(.ROTOR_ID(1)) u_rotor1 (
        .fwdIn    (plugFwd),
        .bwdIn    (r2Bwd),
        .position (pos.r1),
        .fwdOut   (r1Fwd),
        .bwdOut   (r1Bwd)
    );

    rotorWheel #(.ROTOR_ID(2)) u_rotor2 (
        .fwdIn    (r1Fwd),
        .bwdIn    (r3Bwd),
        .position (pos.r2),
        .fwdOut   (r2Fwd),
        .bwdOut   (r2Bwd)
    );

    rotorWheel #(.ROTOR_ID(3)) u_rotor3 (
        .fwdIn    (r2Fwd),
        .bwdIn    (reflected),
        .position (pos.r3),
        .fwdOut   (r3Fwd),
        .bwdOut   (r3Bwd)
    );

    // Turn around at the fixed reflector
    assign reflected = REFLECT_TABLE[r3Fwd];

    assign plugBwd    = PLUG_TABLE[r1Bwd];
    assign cipherChar = CHAR_A + asciiChar_t'(plugBwd);

    always_ff @(posedge load or negedge arstN) begin
        if (!arstN) begin
            outChar <= '0;
        end else if (advance) begin
            outChar <= cipherChar;
        end
    end

    // Control must only step on a valid letter
    assertAdvanceOnLetter: assert property (
        @(posedge load) disable iff (!arstN)
        advance |-> isLetter
    );

endmodule

`default_nettype wire

//--- rtl/enigmaTop.sv
// Cipher machine top with control FSM, rotor stepper and letter scrambler
`timescale 1ns/1ps
`default_nettype none

module enigmaTop
    import enigma_pkg::*;
(
    input  logic       load,
    input  logic       arstN,
    input  logic       setStart,
    input  rotorPos_t  startPos,
    input  logic       charValid,
    input  asciiChar_t charIn,
    output logic       ready,
    output logic       outValid,
    output asciiChar_t outChar,
    output logic       charError
);

    logic      loadPos;
    logic      advance;
    logic      isLetter;
    rotorPos_t pos;

    enigmaControl u_control (
        .load      (load),
        .arstN     (arstN),
        .setStart  (setStart),
        .charValid (charValid),
        .isLetter  (isLetter),
        .loadPos   (loadPos),
        .advance   (advance),
        .ready     (ready),
        .outValid  (outValid),
        .charError (charError)
    );

    rotorStepper u_stepper (
        .load     (load),
        .arstN    (arstN),
        .loadPos  (loadPos),
        .startPos (startPos),
        .advance  (advance),
        .pos      (pos)
    );

    letterScrambler u_scrambler (
        .load     (load),
        .arstN    (arstN),
        .charIn   (charIn),
        .pos      (pos),
        .advance  (advance),
        .isLetter (isLetter),
        .outChar  (outChar)
    );

endmodule

`default_nettype wire

//--- verif/enigmaChecker.sv
// Reference model of rotor positions and cipher, output checks and result counts
`timescale 1ns/1ps
`default_nettype none

`include "enigma_cfg.svh"

module enigmaChecker
    import enigma_pkg::*;
(
    input  logic       load,
    input  logic       arstN,
    input  logic       setStart,
    input  rotorPos_t  startPos,
    input  logic       charValid,
    input  asciiChar_t charIn,
    input  logic       ready,
    input  logic       outValid,
    input  asciiChar_t outChar,
    input  logic       charError,
    output int         errorCount,
    output int         validCount,
    output int         rejectCount
);

    localparam asciiChar_t CHAR_A = "A";

    rotorPos_t  modelPos;
    logic       modelReady;
    logic       expValid;
    logic       expReject;
    asciiChar_t expChar;
    asciiChar_t expIn;
    int         modelErrors;
    int         textErrors = 0;

    assign errorCount = modelErrors + textErrors;

    // Entry point shifts with the rotor, exit shifts back
    function automatic int throughRotor(input int id, input int x, input int p, input bit back);
        int contact;
        int j;
        contact = (x + p) % `ALPHABET_SIZE;
        j = int'(ROTOR_TABLES[id][contact]);
        if (back) begin
            for (int k = 0; k < `ALPHABET_SIZE; k++) begin
                if (int'(ROTOR_TABLES[id][k]) == contact) begin
                    j = k;
                end
            end
        end
        return (j - p + `ALPHABET_SIZE) % `ALPHABET_SIZE;
    endfunction

    function automatic asciiChar_t encipher(input asciiChar_t c, input rotorPos_t p);
        int x;
        x = int'(PLUG_TABLE[int'(c - CHAR_A)]);
        x = throughRotor(0, x, int'(p.r1), 1'b0);
        x = throughRotor(1, x, int'(p.r2), 1'b0);
        x = throughRotor(2, x, int'(p.r3), 1'b0);
        x = int'(REFLECT_TABLE[x]);
        x = throughRotor(2, x, int'(p.r3), 1'b1);
        x = throughRotor(1, x, int'(p.r2), 1'b1);
        x = throughRotor(0, x, int'(p.r1), 1'b1);
        x = int'(PLUG_TABLE[x]);
        return CHAR_A + asciiChar_t'(x);
    endfunction

    // Odometer, a carry only when the lower wheel wraps
    function automatic rotorPos_t stepped(input rotorPos_t p);
        rotorPos_t n;
        n = p;
        n.r1 = letterIdx_t'((int'(p.r1) + 1) % `ALPHABET_SIZE);
        if (p.r1 == `ALPHABET_SIZE - 1) begin
            n.r2 = letterIdx_t'((int'(p.r2) + 1) % `ALPHABET_SIZE);
            if (p.r2 == `ALPHABET_SIZE - 1) begin
                n.r3 = letterIdx_t'((int'(p.r3) + 1) % `ALPHABET_SIZE);
            end
        end
        return n;
    endfunction

    task automatic reportMismatch(input string what);
        $display("MISMATCH at %0t: %s", $time, what);
        modelErrors++;
    endtask

    task automatic compareChar(input asciiChar_t got, input asciiChar_t want, input int idx);
        if (got !== want) begin
            $display("MISMATCH at %0t: deciphered letter %0d is %s, plaintext is %s",
                     $time, idx, got, want);
            textErrors++;
        end
    endtask

    always @(posedge load or negedge arstN) begin
        if (!arstN) begin
            modelPos    = '0;
            modelReady  = 1'b0;
            expValid    = 1'b0;
            expReject   = 1'b0;
            expChar     = '0;
            expIn       = '0;
            modelErrors = 0;
            validCount  <= 0;
            rejectCount <= 0;
        end else begin
            if (ready !== modelReady)
                reportMismatch($sformatf("ready is %b, expected %b", ready, modelReady));
            if (outValid !== expValid)
                reportMismatch($sformatf("outValid is %b, expected %b", outValid, expValid));
            if (charError !== expReject)
                reportMismatch($sformatf("charError is %b, expected %b", charError, expReject));
            if (expValid && outValid) begin
                if (outChar !== expChar)
                    reportMismatch($sformatf("outChar is %s, expected %s", outChar, expChar));
                if (outChar === expIn)
                    reportMismatch($sformatf("letter %s enciphered to itself", expIn));
            end
            if (outValid) validCount <= validCount + 1;
            if (charError) rejectCount <= rejectCount + 1;
            expValid  = 1'b0;
            expReject = 1'b0;
            if (setStart) begin
                modelPos   = startPos;
                modelReady = 1'b1;
            end else if (charValid) begin
                if (modelReady && charIn >= "A" && charIn <= "Z") begin
                    expValid = 1'b1;
                    expIn    = charIn;
                    expChar  = encipher(charIn, modelPos);
                    modelPos = stepped(modelPos);
                end else begin
                    expReject = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/enigmaTb.sv
// Testbench top with clock, reset, seeded random stimulus, DUT and checker
`timescale 1ns/1ps
`default_nettype none

module enigmaTb
    import enigma_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;

    logic       load;
    logic       arstN;
    logic       setStart;
    rotorPos_t  startPos;
    logic       charValid;
    asciiChar_t charIn;
    logic       ready;
    logic       outValid;
    asciiChar_t outChar;
    logic       charError;
    int         errorCount;
    int         validCount;
    int         rejectCount;

    int         seed = 32'hceb3_5845;
    int         sentLetters = 0;
    int         sentBad = 0;
    int         tbFailures = 0;
    int         testsRun = 0;
    int         failedTests = 0;
    asciiChar_t captured[$];

    enigmaTop u_dut (.*);

    enigmaChecker u_check (.*);

    initial begin
        load = 1'b0;
        forever #50 load = ~load;
    end

    always @(posedge load) begin
        if (outValid) captured.push_back(outChar);
    end

    function automatic asciiChar_t randomLetter();
        return asciiChar_t'(8'd65 + $unsigned($random(seed)) % 26);
    endfunction

    function automatic rotorPos_t randomPos();
        rotorPos_t p;
        p.r1 = letterIdx_t'($unsigned($random(seed)) % 26);
        p.r2 = letterIdx_t'($unsigned($random(seed)) % 26);
        p.r3 = letterIdx_t'($unsigned($random(seed)) % 26);
        return p;
    endfunction

    task automatic sendChar(input asciiChar_t c);
        @(posedge load);
        setStart  <= 1'b0;
        charValid <= 1'b1;
        charIn    <= c;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge load);
            setStart  <= 1'b0;
            charValid <= 1'b0;
        end
    endtask

    task automatic loadStart(input rotorPos_t p);
        @(posedge load);
        setStart  <= 1'b1;
        startPos  <= p;
        charValid <= 1'b0;
        idle(1);
    endtask

    task automatic waitOutputs(input string what);
        int cycles;
        cycles = 0;
        while ((validCount < sentLetters || rejectCount < sentBad) && cycles < TIMEOUT_CYCLES) begin
            @(posedge load);
            cycles++;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout at %0t waiting for %s outputs", $time, what);
            tbFailures++;
        end
    endtask

    task automatic endTest(input string name, input int base);
        int errs;
        repeat (3) @(posedge load);
        @(negedge load);
        errs = errorCount + tbFailures - base;
        testsRun++;
        if (errs != 0) failedTests++;
        $display("Test %0d %s: %0d errors", testsRun, name, errs);
    endtask

    initial begin
        rotorPos_t  p;
        asciiChar_t c;
        asciiChar_t plain[$];
        asciiChar_t cipher[$];
        int         base;
        arstN     = 1'b0;
        setStart  = 1'b0;
        startPos  = '0;
        charValid = 1'b0;
        charIn    = '0;
        repeat (2) @(posedge load);
        arstN <= 1'b1;

        base = errorCount + tbFailures;
        sendChar(randomLetter());
        idle(1);
        sentBad++;
        waitOutputs("unset reject");
        endTest("letter before start", base);

        // r2 near its wrap so r3 steps during the run
        base = errorCount + tbFailures;
        p = randomPos();
        p.r2 = letterIdx_t'(24 + $unsigned($random(seed)) % 2);
        loadStart(p);
        for (int i = 0; i < 200; i++) begin
            sendChar(randomLetter());
            idle($unsigned($random(seed)) % 3);
        end
        idle(1);
        sentLetters += 200;
        waitOutputs("random letter");
        endTest("random letters with stepping", base);

        base = errorCount + tbFailures;
        p = randomPos();
        loadStart(p);
        captured.delete();
        for (int i = 0; i < 30; i++) begin
            c = randomLetter();
            plain.push_back(c);
            sendChar(c);
        end
        idle(1);
        sentLetters += 30;
        waitOutputs("encipher");
        cipher = captured;
        captured.delete();
        loadStart(p);
        foreach (cipher[i]) sendChar(cipher[i]);
        idle(1);
        sentLetters += cipher.size();
        waitOutputs("decipher");
        if (captured.size() != plain.size()) begin
            $display("Deciphered %0d letters but the message has %0d", captured.size(),
                     plain.size());
            tbFailures++;
        end
        foreach (plain[i]) begin
            if (i < captured.size()) u_check.compareChar(captured[i], plain[i], i);
        end
        endTest("reciprocity", base);

        base = errorCount + tbFailures;
        for (int i = 0; i < 60; i++) begin
            if ($unsigned($random(seed)) % 3 == 0) begin
                c = asciiChar_t'($random(seed));
                if (c >= "A" && c <= "Z") c = c ^ 8'h80;
                sentBad++;
            end else begin
                c = randomLetter();
                sentLetters++;
            end
            sendChar(c);
        end
        idle(1);
        waitOutputs("mixed stream");
        endTest("non-letters rejected", base);

        // Letter in the load cycle is dropped
        base = errorCount + tbFailures;
        @(posedge load);
        setStart  <= 1'b1;
        startPos  <= randomPos();
        charValid <= 1'b1;
        charIn    <= randomLetter();
        idle(1);
        for (int i = 0; i < 10; i++) begin
            sendChar(randomLetter());
            sentLetters++;
        end
        idle(1);
        waitOutputs("post-load letter");
        endTest("letter dropped at load", base);

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, failedTests,
                 errorCount + tbFailures);
        if (failedTests == 0 && errorCount + tbFailures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/enigma_pkg.sv
rtl/enigmaControl.sv
rtl/rotorStepper.sv
rtl/rotorWheel.sv
rtl/letterScrambler.sv
rtl/enigmaTop.sv
verif/enigmaChecker.sv
verif/enigmaTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module enigmaTb -Mdir obj_dir -o enigmaSim \
    && ./obj_dir/enigmaSim | tee /dev/stderr | grep -qx "Done: no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
